//--- flist.f
+incdir+include
hdl/uart_bridge_pkg.sv
hdl/uart_rx.sv
hdl/char_decode.sv
hdl/cmd_exec.sv
hdl/resp_format.sv
hdl/uart_tx.sv
hdl/uart_bridge_top.sv
test/uart_bridge_chk.sv
test/tb_uart_bridge.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the UART bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_uart_bridge \
    -o sim_uart_bridge \
    && ./obj_dir/sim_uart_bridge 2>&1 | tee sim.log
grep -qxF '** PASS **' sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge;

    localparam int BIT_CLKS     = 8;
    localparam int LINE_TIMEOUT = 2000;  // cycles, a full response takes 720

    logic i_clk;
    logic i_rst_n;
    logic i_rx;
    logic o_tx;

    // reference model state
    logic [31:0] ref_regs [16];
    logic [3:0]  ref_addr;
    logic [7:0]  ref_cmd;    // letter of the open word, zero when none is open
    logic [31:0] ref_data;

    string exp_lines[$];
    string rx_lines[$];
    string cur_test;
    int    n_exp;
    int    n_cmp;

    uart_bridge_top #(.CLKS_PER_BIT(BIT_CLKS)) dut (
        .i_clk, .i_rst_n, .i_rx, .o_tx
    );

    always #50 i_clk = ~i_clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input string exp, input string act);
        if (exp != act)
            stop_on_error($sformatf("mismatch %s: expected %s, actual %s", name, exp, act));
    endtask

    // one host character against the model, returns the expected line or ""
    function automatic string model_char(input logic [7:0] c);
        logic [7:0] k;
        logic [3:0] nib;
        string      resp;
        k    = c & 8'h7f;
        resp = "";
        if ((k >= 8'h30 && k <= 8'h39) || (k >= 8'h61 && k <= 8'h66)) begin
            nib = (k <= 8'h39) ? 4'(k - 8'h30) : 4'(k - 8'h57);
            if (ref_cmd != 8'h00) ref_data = {ref_data[27:0], nib};  // only inside a word
        end else if (k == "R" || k == "W" || k == "A" || k == "S" || k == "E") begin
            // close the open word and run it
            case (ref_cmd)
                "A":     ref_addr = ref_data[3:0];
                "W":     ref_regs[ref_addr] = ref_data;
                "R":     resp = $sformatf("%08h", ref_regs[ref_addr]);
                default: ;
            endcase
            ref_cmd  = k;
            ref_data = '0;
        end else begin
            ref_cmd = 8'h00;  // junk drops the word
        end
        return resp;
    endfunction

    task automatic send_char(input logic [7:0] c);
        string      resp;
        logic [9:0] frame;
        resp  = model_char(c);
        frame = {1'b1, c, 1'b0};  // stop, data lsb first, start
        if (resp.len() > 0) begin
            exp_lines.push_back(resp);
            n_exp++;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            i_rx = frame[i];
            repeat (BIT_CLKS - 1) @(negedge i_clk);
        end
    endtask

    task automatic send_str(input string s);
        for (int i = 0; i < s.len(); i++) send_char(s[i]);
    endtask

    task automatic wait_lines();
        int waited;
        waited = 0;
        while (n_cmp < n_exp) begin
            @(negedge i_clk);
            waited++;
            if (waited > LINE_TIMEOUT)
                stop_on_error($sformatf("no response line on o_tx in time during %s", cur_test));
        end
    endtask

    // rebuilds bytes from o_tx, sampled mid bit on falling edges
    initial begin : tx_monitor
        logic [7:0] b;
        string      cur;
        cur = "";
        forever begin
            @(negedge i_clk);
            if (i_rst_n === 1'b1 && o_tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge i_clk);
                if (o_tx) stop_on_error("start bit on o_tx did not hold for half a bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge i_clk);
                    b[i] = o_tx;
                end
                repeat (BIT_CLKS) @(negedge i_clk);
                if (!o_tx) stop_on_error("stop bit on o_tx is low");
                if (b == 8'h0a) begin
                    rx_lines.push_back(cur);
                    cur = "";
                end else begin
                    cur = $sformatf("%s%c", cur, b);
                end
            end
        end
    end

    // pairs each received line with the model's line, in order
    initial begin : compare_lines
        string act;
        forever begin
            @(negedge i_clk);
            if (rx_lines.size() > 0) begin
                act = rx_lines.pop_front();
                if (exp_lines.size() == 0)
                    stop_on_error($sformatf("unexpected line %s on o_tx during %s", act, cur_test));
                check_equal(cur_test, exp_lines.pop_front(), act);
                n_cmp++;
            end
        end
    end

    initial begin : main_flow
        logic [31:0] v;
        string       digits;
        int          order [16];
        int          j;
        int          t;
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_rx     = 1'b1;  // idle line
        n_exp    = 0;
        n_cmp    = 0;
        ref_addr = '0;
        ref_cmd  = 8'h00;
        ref_data = '0;
        for (int i = 0; i < 16; i++) ref_regs[i] = '0;
        void'($urandom(32'h8e442e2c));
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (5) @(negedge i_clk);

        cur_test = "write_read";
        v = $urandom;
        send_str($sformatf("A3W%08hRE", v));
        wait_lines();

        cur_test = "reset_state";
        send_str("A7RE");
        wait_lines();

        cur_test = "long_digits";
        digits = "";
        for (int i = 0; i < 12; i++) digits = $sformatf("%s%1h", digits, 4'($urandom));
        send_str({"A5W", digits, "RE"});
        wait_lines();

        // z kills the W word, the S word runs nothing, address 3 keeps its value
        cur_test = "junk_and_s";
        send_str("A3W1234z5678S9abcERE");
        wait_lines();

        cur_test = "random_sequence";
        for (int i = 0; i < 16; i++) begin
            send_str($sformatf("A%1hW%08hE", 4'(i), $urandom));
            order[i] = i;
        end
        for (int i = 15; i > 0; i--) begin  // shuffle the read order
            j        = int'($urandom % (i + 1));
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 16; i++) begin
            send_str($sformatf("A%1hRE", 4'(order[i])));
            wait_lines();
        end

        repeat (200) @(negedge i_clk);  // room for a stray line
        if (n_cmp == n_exp && n_exp == 20 && rx_lines.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d of %0d expected lines checked", n_cmp, n_exp));
        end
    end

endmodule

//--- test/uart_bridge_chk.sv
`timescale 1ns/1ps

module uart_bridge_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_excl_a,  // never high in the same cycle as i_excl_b
    input logic i_excl_b,
    input logic i_pulse    // single cycle strobe
);

    a_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_excl_a && i_excl_b)
    ) else $error("%m: strobe high while the other side is active");

    a_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_pulse |=> !i_pulse
    ) else $error("%m: strobe held for more than one cycle");

endmodule

// read strobe against a bank write; i_stb is o_rx_stb one decoder stage later
bind cmd_exec uart_bridge_chk u_chk (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_excl_a (o_rd_stb),
    .i_excl_b (wr_en),
    .i_pulse  (i_stb)
);

// byte strobe against transmitter busy
bind resp_format uart_bridge_chk u_chk (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_excl_a (o_tx_stb),
    .i_excl_b (i_tx_busy),
    .i_pulse  (i_rd_stb)
);

//--- hdl/uart_bridge_top.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_bridge_top #(
    parameter int CLKS_PER_BIT = `UB_CLKS_PER_BIT
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_rx,
    output logic o_tx
);

    import uart_bridge_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_stb;
    dec_char_t  dec_char;
    logic       dec_stb;
    rd_resp_t   rd_resp;
    logic       rd_stb;
    logic [7:0] tx_byte;
    logic       tx_stb;
    logic       tx_busy;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .i_clk, .i_rst_n, .i_rx,
        .o_rx_byte(rx_byte), .o_rx_stb(rx_stb)
    );

    char_decode u_dec (
        .i_clk, .i_rst_n,
        .i_byte(rx_byte), .i_stb(rx_stb),
        .o_char(dec_char), .o_stb(dec_stb)
    );

    cmd_exec u_exec (
        .i_clk, .i_rst_n,
        .i_char(dec_char), .i_stb(dec_stb),
        .o_rd(rd_resp), .o_rd_stb(rd_stb)
    );

    resp_format u_resp (
        .i_clk, .i_rst_n,
        .i_rd(rd_resp), .i_rd_stb(rd_stb), .i_tx_busy(tx_busy),
        .o_tx_byte(tx_byte), .o_tx_stb(tx_stb)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .i_clk, .i_rst_n,
        .i_byte(tx_byte), .i_stb(tx_stb),
        .o_tx, .o_busy(tx_busy)
    );

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UB_CLKS_PER_BIT
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [7:0] i_byte,
    input  logic       i_stb,
    output logic       o_tx,
    output logic       o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [9:0]       frame;    // bit 0 is on the line
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frame   <= '1;
            cnt     <= '0;
            bit_idx <= '0;
            o_busy  <= 1'b0;
        end else if (!o_busy) begin
            if (i_stb) begin
                frame   <= {1'b1, i_byte, 1'b0};  // stop, data lsb first, start
                cnt     <= '0;
                bit_idx <= '0;
                o_busy  <= 1'b1;
            end
        end else if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt     <= '0;
            frame   <= {1'b1, frame[9:1]};  // ones fill in behind
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) o_busy <= 1'b0;  // end of stop bit
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_tx = frame[0];

endmodule

//--- hdl/resp_format.sv
`timescale 1ns/1ps

module resp_format (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  uart_bridge_pkg::rd_resp_t i_rd,
    input  logic                      i_rd_stb,
    input  logic                      i_tx_busy,
    output logic [7:0]                o_tx_byte,
    output logic                      o_tx_stb
);

    typedef enum logic {RF_IDLE, RF_WAIT} rf_state_e;

    rf_state_e   state;
    logic [3:0]  cnt;     // bytes issued so far
    logic [31:0] sh;      // remaining nibbles, next one on top
    logic        take;
    logic        next_ok;
    logic        tx_free;

    function automatic logic [7:0] hex_ascii(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + {4'h0, n};
        return 8'h57 + {4'h0, n};  // 0xa -> 'a'
    endfunction

    // busy rises one cycle after a strobe
    assign tx_free = !i_tx_busy && !o_tx_stb;

    // new reads are only accepted between responses
    assign take    = (state == RF_IDLE) && i_rd_stb;
    assign next_ok = (state == RF_WAIT) && tx_free && (cnt != 4'd9);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= RF_IDLE;
            cnt      <= '0;
            o_tx_stb <= 1'b0;
        end else begin
            o_tx_stb <= take || next_ok;
            if (take) begin
                state <= RF_WAIT;
                cnt   <= 4'd1;
            end else if (next_ok) begin
                cnt <= cnt + 1'b1;
            end else if (state == RF_WAIT && tx_free) begin
                state <= RF_IDLE;  // line feed has gone out
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_tx_byte <= hex_ascii(i_rd.data[31:28]);
            sh        <= {i_rd.data[27:0], 4'h0};
        end else if (next_ok) begin
            if (cnt == 4'd8) o_tx_byte <= 8'h0a;  // terminating line feed
            else             o_tx_byte <= hex_ascii(sh[31:28]);
            sh <= {sh[27:0], 4'h0};
        end
    end

endmodule

//--- hdl/cmd_exec.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module cmd_exec (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  uart_bridge_pkg::dec_char_t i_char,
    input  logic                       i_stb,
    output uart_bridge_pkg::rd_resp_t  o_rd,
    output logic                       o_rd_stb
);

    import uart_bridge_pkg::*;

    exec_word_t            open_word;
    logic [`UB_ADDR_W-1:0] addr;
    logic [`UB_DATA_W-1:0] regs [`UB_REG_COUNT];

    logic cmd_in;
    logic digit_in;
    logic junk_in;
    logic wr_en;
    logic rd_en;
    logic addr_en;

    assign cmd_in   = i_stb && i_char.is_cmd;
    assign digit_in = i_stb && i_char.is_digit;
    assign junk_in  = i_stb && !i_char.is_cmd && !i_char.is_digit;

    // a command letter closes the open word and runs it
    // S, E and a discarded word fall through with no effect
    assign wr_en   = cmd_in && (open_word.cmd == CMD_WRITE);
    assign rd_en   = cmd_in && (open_word.cmd == CMD_READ);
    assign addr_en = cmd_in && (open_word.cmd == CMD_ADDR);

    // word assembly
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            open_word <= '{cmd: CMD_NONE, data: '0};
        end else if (cmd_in) begin
            open_word <= '{cmd: i_char.cmd, data: '0};  // new word starts empty
        end else if (digit_in && open_word.cmd != CMD_NONE) begin
            // older digits fall off the top after eight
            open_word.data <= {open_word.data[`UB_DATA_W-5:0], i_char.nibble};
        end else if (junk_in) begin
            open_word.cmd <= CMD_NONE;  // drop word, wait for next letter
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr <= '0;
        end else if (addr_en) begin
            addr <= open_word.data[`UB_ADDR_W-1:0];
        end
    end

    // register bank, cleared by reset so unwritten reads return zero
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `UB_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[addr] <= open_word.data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) o_rd_stb <= 1'b0;
        else          o_rd_stb <= rd_en;
    end

    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            o_rd.addr <= addr;
            o_rd.data <= regs[addr];
        end
    end

endmodule

//--- hdl/char_decode.sv
`timescale 1ns/1ps

module char_decode (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic [7:0]                 i_byte,
    input  logic                       i_stb,
    output uart_bridge_pkg::dec_char_t o_char,
    output logic                       o_stb
);

    import uart_bridge_pkg::*;

    dec_char_t dec_next;

    // lookup on the low seven bits, bit 7 is don't care
    always_comb begin
        dec_next = '{is_digit: 1'b0, is_cmd: 1'b0, nibble: 4'h0, cmd: CMD_NONE};
        case (i_byte[6:0]) inside
            [7'h30:7'h39]: begin
                dec_next.is_digit = 1'b1;
                dec_next.nibble   = i_byte[3:0];
            end
            [7'h61:7'h66]: begin
                dec_next.is_digit = 1'b1;
                dec_next.nibble   = i_byte[3:0] + 4'd9;  // 'a' -> 0xa
            end
            7'h52: begin
                dec_next.is_cmd = 1'b1;
                dec_next.cmd    = CMD_READ;
            end
            7'h57: begin
                dec_next.is_cmd = 1'b1;
                dec_next.cmd    = CMD_WRITE;
            end
            7'h41: begin
                dec_next.is_cmd = 1'b1;
                dec_next.cmd    = CMD_ADDR;
            end
            7'h53: begin
                dec_next.is_cmd = 1'b1;
                dec_next.cmd    = CMD_SPECIAL;
            end
            7'h45: begin
                dec_next.is_cmd = 1'b1;
                dec_next.cmd    = CMD_END;
            end
            default: ;  // junk
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) o_stb <= 1'b0;
        else          o_stb <= i_stb;
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) o_char <= dec_next;
    end

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UB_CLKS_PER_BIT
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_rx,
    output logic [7:0] o_rx_byte,
    output logic       o_rx_stb
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int HALF  = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_s;
    logic             sample;

    // two flop synchronizer, line idles high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_s    <= rx_meta;
        end
    end

    // mid-bit sample point for data and stop bits
    assign sample = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            o_rx_stb <= 1'b0;
        end else begin
            o_rx_stb <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) state <= RX_START;  // falling start edge
                end
                RX_START: begin
                    if (cnt == CNT_W'(HALF - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // stop bit value is not checked
                    if (sample) begin
                        o_rx_stb <= 1'b1;
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && sample) o_rx_byte <= {rx_s, o_rx_byte[7:1]};
    end

endmodule

//--- hdl/uart_bridge_pkg.sv
`include "uart_bridge_macros.svh"

package uart_bridge_pkg;

    // low bits follow the command codes of the old decoder
    typedef enum logic [2:0] {
        CMD_READ    = 3'd0,  // 'R'
        CMD_WRITE   = 3'd1,  // 'W'
        CMD_ADDR    = 3'd2,  // 'A'
        CMD_SPECIAL = 3'd3,  // 'S', reserved
        CMD_END     = 3'd4,  // 'E'
        CMD_NONE    = 3'd7   // no open word
    } cmd_e;

    // one received character after lookup
    // junk has both flags low
    typedef struct packed {
        logic       is_digit;
        logic       is_cmd;
        logic [3:0] nibble;
        cmd_e       cmd;
    } dec_char_t;

    // word being assembled, or the one just closed
    typedef struct packed {
        cmd_e                  cmd;
        logic [`UB_DATA_W-1:0] data;
    } exec_word_t;

    // result of an executed read
    typedef struct packed {
        logic [`UB_ADDR_W-1:0] addr;
        logic [`UB_DATA_W-1:0] data;
    } rd_resp_t;

endpackage

//--- include/uart_bridge_macros.svh
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// serial bit period in system clocks, 100 MHz at 115200 baud
`define UB_CLKS_PER_BIT 868

// register bank size
`define UB_REG_COUNT 16

// width of one assembled word and of every register
`define UB_DATA_W 32

// register address width, log2 of the bank size
`define UB_ADDR_W 4

`endif
